//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = media_loader_tb
FILELIST  = sim.f

.PHONY: sim clean

# Build and run, pass only when the summary reports a clean run
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

//--- design/image_loader.sv
// Image loader: places ROM and PRG bytes and patches BASIC pointers after a PRG load
`timescale 1ns/10ps
`include "loader_defs.svh"

module image_loader (
    input  logic                   clk_sys,
    input  logic                   reset,
    input  loader_pkg::dl_stream_t dl_i,
    input  logic                   no_load_addr_i,
    output loader_pkg::load_wr_t   wr_o,
    output logic                   force_reset_o
);
    import loader_pkg::*;

    image_kind_t        kind;
    logic               rom_wr;
    logic               prg_wr;
    logic               prg_dl_d;
    logic               prg_header;
    logic               prg_internal;
    logic [`CPU_AW-1:0] prg_addr;
    logic [`CPU_AW-1:0] prg_next;
    logic               rom_hit;
    logic               rom_internal;
    logic [`MEM_AW-1:0] rom_addr;
    logic [4:0]         inject_step;
    logic [7:0]         zp_addr;
    logic [7:0]         zp_data;
    logic               auto_reset;

    assign kind   = classify_index(dl_i.active, dl_i.index);
    assign rom_wr = (kind == KIND_ROM) && dl_i.wr;
    assign prg_wr = (kind == KIND_PRG) && dl_i.wr;

    // ====================
    // ROM mapping
    // ====================
    always_comb begin
        rom_hit      = 1'b1;
        rom_internal = 1'b0;
        rom_addr     = '0;
        case (dl_i.offset[15:13])
            3'b010: rom_addr = {7'h00, 3'b111, dl_i.offset[12:0]};
            3'b011: rom_addr = {7'h01, 3'b111, dl_i.offset[12:0]};
            3'b100: rom_addr = {7'h00, 3'b110, dl_i.offset[12:0]};
            3'b101: begin
                // Character ROM sits inside the core
                rom_addr     = {7'h00, 4'b1000, dl_i.offset[11:0]};
                rom_internal = 1'b1;
            end
            default: rom_hit = 1'b0;
        endcase
    end

    // ====================
    // PRG placement
    // ====================
    assign prg_header = !no_load_addr_i && (dl_i.offset < 24'd2);

    always_comb begin
        if (no_load_addr_i && dl_i.offset == '0) begin
            prg_next = `PRG_CART_BASE;
        end else if (!no_load_addr_i && dl_i.offset == 24'd2) begin
            prg_next = prg_addr;
        end else if (prg_addr == `PRG_CEILING) begin
            prg_next = prg_addr;
        end else begin
            prg_next = prg_addr + 1'b1;
        end
    end

    // Low RAM, 4K block and colour RAM are in the core
    assign prg_internal = (prg_next[15:10] == 6'b000000) ||
                          (prg_next[15:12] == 4'h1) ||
                          (prg_next[15:10] == 6'b100101);

    // Zero-page pointer targets, low and high bytes alternate
    always_comb begin
        case (inject_step[3:1])
            3'd0:    zp_addr = 8'h2D;
            3'd1:    zp_addr = 8'h2E;
            3'd2:    zp_addr = 8'h2F;
            3'd3:    zp_addr = 8'h30;
            3'd4:    zp_addr = 8'h31;
            3'd5:    zp_addr = 8'h32;
            3'd6:    zp_addr = 8'hAE;
            default: zp_addr = 8'hAF;
        endcase
    end

    assign zp_data = inject_step[1] ? prg_addr[15:8] : prg_addr[7:0];

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            wr_o.we       <= 1'b0;
            force_reset_o <= 1'b0;
            prg_dl_d      <= 1'b0;
            inject_step   <= '0;
            auto_reset    <= 1'b0;
        end else begin
            wr_o.we       <= 1'b0;
            force_reset_o <= 1'b0;
            prg_dl_d      <= (kind == KIND_PRG);

            if (rom_wr && rom_hit) begin
                wr_o.we       <= 1'b1;
                wr_o.addr     <= rom_addr;
                wr_o.data     <= dl_i.data;
                wr_o.internal <= rom_internal;
            end

            if (prg_wr) begin
                if (prg_header) begin
                    if (dl_i.offset[0]) begin
                        prg_addr[15:8] <= dl_i.data;
                    end else begin
                        prg_addr[7:0] <= dl_i.data;
                    end
                end else begin
                    prg_addr      <= prg_next;
                    wr_o.we       <= 1'b1;
                    wr_o.addr     <= {{(`MEM_AW-`CPU_AW){1'b0}}, prg_next};
                    wr_o.data     <= dl_i.data;
                    wr_o.internal <= prg_internal;
                    if (prg_next == `PRG_CART_BASE) begin
                        auto_reset <= 1'b1;
                    end
                end
            end

            // Sequencer runs 1..31 after the PRG stream ends
            if (inject_step != '0) begin
                inject_step <= inject_step + 1'b1;
            end
            if (prg_dl_d && kind != KIND_PRG) begin
                inject_step <= 5'd1;
            end

            if (inject_step[0] && inject_step < 5'd16) begin
                wr_o.we       <= 1'b1;
                wr_o.addr     <= {{(`MEM_AW-8){1'b0}}, zp_addr};
                wr_o.data     <= zp_data;
                wr_o.internal <= 1'b1;
            end

            if (inject_step == `INJECT_LAST) begin
                force_reset_o <= auto_reset;
                auto_reset    <= 1'b0;
            end
        end
    end

endmodule

//--- design/loader_defs.svh
// Loader definitions: memory map, host image indices and sequencer limits
`ifndef LOADER_DEFS_SVH
`define LOADER_DEFS_SVH

// ====================
// Address widths
// ====================
`define MEM_AW 23
`define CPU_AW 16

// ====================
// Memory map
// ====================
// Tape images live above the 128K system area
`define TAP_MEM_START 23'h20000
`define PRG_CART_BASE 16'hA000
// Last address a PRG may fill, ROMs start above
`define PRG_CEILING 16'hBFFF

// ====================
// Host image indices
// ====================
`define IDX_ROM 8'h00
`define IDX_PRG 8'h01
`define IDX_PRG_ALT 8'h41
`define IDX_TAP 8'h81

// Byte holding the TAP version in bit 0
`define TAP_VERSION_OFFSET 24'h00000C

// Final step of the zero-page injection sequencer
`define INJECT_LAST 5'd31

`endif

//--- design/loader_pkg.sv
// Loader package: bus structs, image kinds and host index decoding
`include "loader_defs.svh"

package loader_pkg;

    // Host download stream, one byte per wr strobe
    typedef struct packed {
        logic        active;
        logic [7:0]  index;
        logic        wr;
        logic [23:0] offset;
        logic [7:0]  data;
    } dl_stream_t;

    typedef enum logic [1:0] {
        KIND_NONE,
        KIND_ROM,
        KIND_PRG,
        KIND_TAP
    } image_kind_t;

    // Write issued by a loader, internal targets the core RAM
    typedef struct packed {
        logic [`MEM_AW-1:0] addr;
        logic [7:0]         data;
        logic               we;
        logic               internal;
    } load_wr_t;

    typedef struct packed {
        logic [`CPU_AW-1:0] addr;
        logic [7:0]         wdata;
        logic               sel;
        logic               r_wn;
    } cpu_req_t;

    typedef struct packed {
        logic [`MEM_AW-1:0] addr;
        logic [7:0]         wdata;
        logic               we;
        logic               oe;
        logic               internal;
    } mem_bus_t;

    typedef struct packed {
        logic [7:0] data;
        logic       wrreq;
    } tap_byte_t;

    function automatic image_kind_t classify_index(input logic active,
                                                   input logic [7:0] index);
        image_kind_t kind;
        kind = KIND_NONE;
        if (active) begin
            case (index)
                `IDX_ROM:               kind = KIND_ROM;
                `IDX_PRG, `IDX_PRG_ALT: kind = KIND_PRG;
                `IDX_TAP:               kind = KIND_TAP;
                default:                kind = KIND_NONE;
            endcase
        end
        return kind;
    endfunction

endpackage

//--- design/media_loader_top.sv
// Media loader top: ROM, PRG and TAP loaders sharing one memory port with the CPU
`timescale 1ns/10ps
`include "loader_defs.svh"

module media_loader_top (
    input  logic                   clk_sys,
    input  logic                   reset,
    input  loader_pkg::dl_stream_t dl_i,
    input  logic                   no_load_addr_i,
    input  logic                   ntsc_i,
    input  logic                   p2_h_i,
    input  loader_pkg::cpu_req_t   cpu_i,
    input  logic [7:0]             mem_rdata_i,
    input  logic                   tap_fifo_full_i,
    output loader_pkg::mem_bus_t   mem_o,
    output logic                   force_reset_o,
    output loader_pkg::tap_byte_t  tap_o,
    output logic                   tap_restart_o,
    output logic                   tap_version_o
);
    import loader_pkg::*;

    load_wr_t           img_wr;
    load_wr_t           tap_wr;
    logic [`MEM_AW-1:0] tap_last_addr;
    logic [`MEM_AW-1:0] play_addr;
    logic               tap_oe;

    image_loader image_loader_i (
        .clk_sys        (clk_sys),
        .reset          (reset),
        .dl_i           (dl_i),
        .no_load_addr_i (no_load_addr_i),
        .wr_o           (img_wr),
        .force_reset_o  (force_reset_o)
    );

    tap_loader tap_loader_i (
        .clk_sys         (clk_sys),
        .reset           (reset),
        .dl_i            (dl_i),
        .wr_o            (tap_wr),
        .tap_last_addr_o (tap_last_addr),
        .tap_restart_o   (tap_restart_o),
        .tap_version_o   (tap_version_o)
    );

    tap_player tap_player_i (
        .clk_sys         (clk_sys),
        .reset           (reset),
        .dl_active_i     (dl_i.active),
        .p2_h_i          (p2_h_i),
        .tap_last_addr_i (tap_last_addr),
        .mem_rdata_i     (mem_rdata_i),
        .tap_fifo_full_i (tap_fifo_full_i),
        .play_addr_o     (play_addr),
        .oe_o            (tap_oe),
        .tap_o           (tap_o)
    );

    mem_router mem_router_i (
        .dl_i        (dl_i),
        .p2_h_i      (p2_h_i),
        .ntsc_i      (ntsc_i),
        .cpu_i       (cpu_i),
        .img_wr_i    (img_wr),
        .tap_wr_i    (tap_wr),
        .play_addr_i (play_addr),
        .tap_oe_i    (tap_oe),
        .mem_o       (mem_o)
    );

endmodule

//--- design/mem_router.sv
// Memory router: shares the external memory port between loaders, CPU and tape player
`timescale 1ns/10ps
`include "loader_defs.svh"

module mem_router (
    input  loader_pkg::dl_stream_t dl_i,
    input  logic                   p2_h_i,
    input  logic                   ntsc_i,
    input  loader_pkg::cpu_req_t   cpu_i,
    input  loader_pkg::load_wr_t   img_wr_i,
    input  loader_pkg::load_wr_t   tap_wr_i,
    input  logic [`MEM_AW-1:0]     play_addr_i,
    input  logic                   tap_oe_i,
    output loader_pkg::mem_bus_t   mem_o
);
    import loader_pkg::*;

    load_wr_t           ld_wr;
    logic               load_sel;
    logic               kernal_bank;
    logic               cpu_rd;
    logic               cpu_wr;
    logic [`MEM_AW-1:0] cpu_addr;

    // Only one loader writes at a time
    assign ld_wr = img_wr_i.we ? img_wr_i : tap_wr_i;

    // Trailing and injection writes arrive after active falls
    assign load_sel = dl_i.active | ld_wr.we;

    // ====================
    // CPU side
    // ====================
    // Kernal area is banked by video standard
    assign kernal_bank = ntsc_i & (cpu_i.addr[`CPU_AW-1:13] == 3'b111);
    assign cpu_addr    = {{(`MEM_AW-`CPU_AW-1){1'b0}}, kernal_bank, cpu_i.addr};
    assign cpu_rd      = cpu_i.sel & cpu_i.r_wn;
    assign cpu_wr      = cpu_i.sel & ~cpu_i.r_wn;

    // ====================
    // Port select
    // ====================
    always_comb begin
        if (load_sel) begin
            mem_o.addr = ld_wr.addr;
        end else if (p2_h_i) begin
            mem_o.addr = cpu_addr;
        end else begin
            mem_o.addr = play_addr_i;
        end
        mem_o.wdata    = load_sel ? ld_wr.data : cpu_i.wdata;
        mem_o.we       = ld_wr.we | (cpu_wr & p2_h_i & ~load_sel);
        mem_o.oe       = ~load_sel & (p2_h_i ? cpu_rd : tap_oe_i);
        mem_o.internal = ld_wr.we & ld_wr.internal;
    end

endmodule

//--- design/tap_loader.sv
// TAP loader: stores tape bytes from the tape base and tracks the image end and version
`timescale 1ns/10ps
`include "loader_defs.svh"

module tap_loader (
    input  logic                   clk_sys,
    input  logic                   reset,
    input  loader_pkg::dl_stream_t dl_i,
    output loader_pkg::load_wr_t   wr_o,
    output logic [`MEM_AW-1:0]     tap_last_addr_o,
    output logic                   tap_restart_o,
    output logic                   tap_version_o
);
    import loader_pkg::*;

    logic               tap_dl;
    logic [`MEM_AW-1:0] tap_addr;
    logic [`MEM_AW-1:0] tap_next;
    logic               restart_q;

    assign tap_dl   = (classify_index(dl_i.active, dl_i.index) == KIND_TAP);
    assign tap_next = (dl_i.offset == '0) ? `TAP_MEM_START : tap_addr + 1'b1;

    assign tap_last_addr_o = tap_addr;
    assign tap_restart_o   = restart_q | tap_dl;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            wr_o.we       <= 1'b0;
            // Empty tape ends just below the start address
            tap_addr      <= `TAP_MEM_START - 1'b1;
            tap_version_o <= 1'b0;
            restart_q     <= 1'b1;
        end else begin
            wr_o.we   <= 1'b0;
            restart_q <= 1'b0;
            if (tap_dl && dl_i.wr) begin
                tap_addr      <= tap_next;
                wr_o.we       <= 1'b1;
                wr_o.addr     <= tap_next;
                wr_o.data     <= dl_i.data;
                wr_o.internal <= 1'b0;
                if (dl_i.offset == `TAP_VERSION_OFFSET) begin
                    tap_version_o <= dl_i.data[0];
                end
            end
        end
    end

endmodule

//--- design/tap_player.sv
// Tape player: fetches stored tape bytes in the low CPU phase and streams them out
`timescale 1ns/10ps
`include "loader_defs.svh"

module tap_player (
    input  logic                  clk_sys,
    input  logic                  reset,
    input  logic                  dl_active_i,
    input  logic                  p2_h_i,
    input  logic [`MEM_AW-1:0]    tap_last_addr_i,
    input  logic [7:0]            mem_rdata_i,
    input  logic                  tap_fifo_full_i,
    output logic [`MEM_AW-1:0]    play_addr_o,
    output logic                  oe_o,
    output loader_pkg::tap_byte_t tap_o
);
    import loader_pkg::*;

    logic               p2_h_d;
    logic               p2_fall;
    logic               p2_rise;
    logic [`MEM_AW-1:0] tap_end;
    logic [7:0]         tap_data;
    logic               tap_wrreq;

    assign p2_fall = p2_h_d && !p2_h_i;
    assign p2_rise = !p2_h_d && p2_h_i;

    // Play through the last stored byte
    assign tap_end = tap_last_addr_i + 1'b1;

    assign tap_o.data  = tap_data;
    assign tap_o.wrreq = tap_wrreq;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            p2_h_d      <= 1'b0;
            play_addr_o <= `TAP_MEM_START;
            oe_o        <= 1'b0;
            tap_wrreq   <= 1'b0;
        end else begin
            p2_h_d    <= p2_h_i;
            tap_wrreq <= 1'b0;
            if (dl_active_i) begin
                play_addr_o <= `TAP_MEM_START;
            end
            if (p2_fall && play_addr_o != tap_end && !dl_active_i &&
                !tap_fifo_full_i && !oe_o) begin
                oe_o <= 1'b1;
            end
            // Byte goes out when the CPU takes the bus back
            if (p2_rise && oe_o) begin
                tap_wrreq   <= 1'b1;
                oe_o        <= 1'b0;
                play_addr_o <= play_addr_o + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (!p2_h_i && oe_o) begin
            tap_data <= mem_rdata_i;
        end
    end

endmodule

//--- sim.f
+incdir+design
design/loader_pkg.sv
design/image_loader.sv
design/tap_loader.sv
design/tap_player.sv
design/mem_router.sv
design/media_loader_top.sv
tests/media_loader_asserts.sv
tests/media_loader_tb.sv

//--- tests/media_loader_asserts.sv
// Media loader port checks: bus exclusivity, single-cycle pulses and download ownership
`timescale 1ns/10ps

module media_loader_asserts (
    input logic                   clk_sys,
    input logic                   reset,
    input loader_pkg::dl_stream_t dl_i,
    input loader_pkg::mem_bus_t   mem_i,
    input logic                   force_reset_i,
    input loader_pkg::tap_byte_t  tap_i
);

    we_oe_exclusive: assert property (@(posedge clk_sys) disable iff (reset)
        !(mem_i.we && mem_i.oe))
        else $error("Memory we and oe high in the same cycle");

    force_reset_single: assert property (@(posedge clk_sys) disable iff (reset)
        force_reset_i |=> !force_reset_i)
        else $error("force_reset_o high for two cycles");

    wrreq_single: assert property (@(posedge clk_sys) disable iff (reset)
        tap_i.wrreq |=> !tap_i.wrreq)
        else $error("Tape wrreq high for two cycles");

    // During a download the port belongs to the loaders
    download_no_read: assert property (@(posedge clk_sys) disable iff (reset)
        dl_i.active |-> !mem_i.oe)
        else $error("Memory read during an active download");

    download_write_source: assert property (@(posedge clk_sys) disable iff (reset)
        (dl_i.active && mem_i.we) |-> $past(dl_i.active && dl_i.wr))
        else $error("Memory write during a download without a host byte");

endmodule

//--- tests/media_loader_tb.sv
// Media loader testbench: drives host downloads, tape phases and CPU accesses against a memory model
`timescale 1ns/10ps
`include "loader_defs.svh"

module media_loader_tb;
    import loader_pkg::*;

    localparam int DRIVE_DELAY = 1;
    // Limit well above the roughly 500 cycles the tests take
    localparam int TIMEOUT_CYCLES = 6000;
    localparam int MEM_WORDS = 1 << 18;
    localparam logic [63:0] ZP_TARGETS = 64'h2D2E_2F30_3132_AEAF;

    typedef struct packed {
        logic [`MEM_AW-1:0] addr;
        logic [7:0]         data;
        logic               internal;
        logic [31:0]        cycle;
    } wr_rec_t;

    logic       clk_sys = 1'b0;
    logic       reset;
    dl_stream_t dl;
    logic       no_load_addr;
    logic       ntsc;
    logic       p2_h;
    cpu_req_t   cpu_req;
    logic [7:0] mem_rdata;
    logic       tap_fifo_full;
    mem_bus_t   mem_bus;
    logic       force_reset;
    tap_byte_t  tap_byte;
    logic       tap_restart;
    logic       tap_version;

    logic [7:0]  mem [0:MEM_WORDS-1];
    logic [7:0]  tap_bytes [0:15];
    wr_rec_t     wr_q [$];
    wr_rec_t     seen;
    logic [7:0]  tap_q [$];
    logic [31:0] lfsr = 32'h1dab_f8e2;
    int          cycles = 0;
    int          errors = 0;
    int          test_base = 0;
    int          passed = 0;
    int          failed = 0;
    int          reset_pulses = 0;
    int          restart_gaps = 0;

    media_loader_top media_loader_top_i (
        .clk_sys         (clk_sys),
        .reset           (reset),
        .dl_i            (dl),
        .no_load_addr_i  (no_load_addr),
        .ntsc_i          (ntsc),
        .p2_h_i          (p2_h),
        .cpu_i           (cpu_req),
        .mem_rdata_i     (mem_rdata),
        .tap_fifo_full_i (tap_fifo_full),
        .mem_o           (mem_bus),
        .force_reset_o   (force_reset),
        .tap_o           (tap_byte),
        .tap_restart_o   (tap_restart),
        .tap_version_o   (tap_version)
    );

    bind media_loader_top media_loader_asserts media_loader_asserts_i (
        .clk_sys       (clk_sys),
        .reset         (reset),
        .dl_i          (dl_i),
        .mem_i         (mem_o),
        .force_reset_i (force_reset_o),
        .tap_i         (tap_o)
    );

    always #50 clk_sys = ~clk_sys;

    always @(posedge clk_sys) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // ====================
    // Memory model and monitors
    // ====================
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = i[7:0] ^ i[15:8] ^ {6'b000000, i[17:16]};
        end
    end

    assign mem_rdata = mem[mem_bus.addr[17:0]];

    // Sampled mid-cycle where all outputs are settled
    always @(negedge clk_sys) begin
        if (!reset) begin
            if (mem_bus.we) begin
                mem[mem_bus.addr[17:0]] = mem_bus.wdata;
                seen.addr     = mem_bus.addr;
                seen.data     = mem_bus.wdata;
                seen.internal = mem_bus.internal;
                seen.cycle    = cycles;
                wr_q.push_back(seen);
            end
            if (force_reset) reset_pulses++;
            if (tap_byte.wrreq) tap_q.push_back(tap_byte.data);
            if (dl.active && dl.index == `IDX_TAP && !tap_restart) restart_gaps++;
        end
    end

    // ====================
    // Helpers
    // ====================
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic random_byte(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            lfsr = lfsr_next(lfsr);
            b[i] = lfsr[0];
        end
    endtask

    task automatic step(input int n);
        repeat (n) begin
            @(posedge clk_sys);
            #DRIVE_DELAY;
        end
    endtask

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0d ns: %s = %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic start_download(input logic [7:0] index);
        dl.index  = index;
        dl.active = 1'b1;
        dl.wr     = 1'b0;
        dl.offset = '0;
        step(1);
    endtask

    // One strobed byte followed by an idle cycle
    task automatic send_byte(input logic [23:0] offset, input logic [7:0] data);
        dl.offset = offset;
        dl.data   = data;
        dl.wr     = 1'b1;
        step(1);
        dl.wr = 1'b0;
        step(1);
    endtask

    task automatic end_download();
        dl.active = 1'b0;
        step(1);
    endtask

    task automatic wait_writes(input int n);
        while (wr_q.size() < n) step(1);
    endtask

    task automatic expect_write(input logic [22:0] addr, input logic [7:0] data,
                                input logic internal);
        wr_rec_t rec;
        if (wr_q.size() == 0) begin
            $display("No memory write was seen for address %h", addr);
            errors++;
        end else begin
            rec = wr_q.pop_front();
            compare("mem_o.addr", rec.addr, addr);
            compare("mem_o.wdata", rec.data, data);
            compare("mem_o.internal", rec.internal, internal);
        end
    endtask

    task automatic none_written(input string what);
        if (wr_q.size() != 0) begin
            $display("Unexpected memory write for %s at address %h", what, wr_q[0].addr);
            errors++;
            wr_q.delete();
        end
    endtask

    // Eight zero-page writes, low and high pointer bytes alternating
    task automatic verify_injection(input logic [15:0] ptr);
        wr_rec_t     rec;
        logic [31:0] last;
        last = '0;
        wait_writes(8);
        for (int i = 0; i < 8; i++) begin
            rec = wr_q.pop_front();
            compare("mem_o.addr", rec.addr, {15'h0000, ZP_TARGETS[63-8*i -: 8]});
            compare("mem_o.wdata", rec.data, i[0] ? ptr[15:8] : ptr[7:0]);
            compare("mem_o.internal", rec.internal, 1'b1);
            if (i > 0) compare("injection write spacing", rec.cycle - last, 2);
            last = rec.cycle;
        end
    endtask

    task automatic phase_cycle();
        p2_h = 1'b0;
        step(2);
        p2_h = 1'b1;
        step(2);
    endtask

    task automatic report_test(input string name);
        int n;
        n = errors - test_base;
        if (n == 0) begin
            $display("%s: ok", name);
            passed++;
        end else begin
            $display("%s: %0d errors", name, n);
            failed++;
        end
        test_base = errors;
    endtask

    // ====================
    // Directed tests
    // ====================
    task automatic rom_download();
        start_download(`IDX_ROM);
        send_byte(24'h001234, 8'h11);
        send_byte(24'h003FFF, 8'h22);
        none_written("a ROM offset below $4000");
        send_byte(24'h004123, 8'h33);
        send_byte(24'h006456, 8'h44);
        send_byte(24'h008789, 8'h55);
        send_byte(24'h00A0AB, 8'h66);
        end_download();
        expect_write(23'h00E123, 8'h33, 1'b0);
        expect_write(23'h01E456, 8'h44, 1'b0);
        expect_write(23'h00C789, 8'h55, 1'b0);
        expect_write(23'h0080AB, 8'h66, 1'b1);
        none_written("the end of the ROM download");
    endtask

    task automatic prg_at_1100();
        reset_pulses = 0;
        start_download(`IDX_PRG);
        send_byte(24'd0, 8'h00);
        send_byte(24'd1, 8'h11);
        for (int i = 0; i < 4; i++) send_byte(24'd2 + i, 8'h40 + i);
        end_download();
        for (int i = 0; i < 4; i++) expect_write(23'h001100 + i, 8'h40 + i, 1'b1);
        verify_injection(16'h1103);
        step(40);
        compare("force_reset_o pulses", reset_pulses, 0);
    endtask

    task automatic cartridge_autostart();
        reset_pulses = 0;
        start_download(`IDX_PRG_ALT);
        send_byte(24'd0, 8'h00);
        send_byte(24'd1, 8'hA0);
        send_byte(24'd2, 8'hC3);
        send_byte(24'd3, 8'hC4);
        end_download();
        expect_write(23'h00A000, 8'hC3, 1'b0);
        expect_write(23'h00A001, 8'hC4, 1'b0);
        verify_injection(16'hA001);
        while (reset_pulses == 0) step(1);
        step(4);
        compare("force_reset_o pulses", reset_pulses, 1);

        // Load near the top of the PRG window
        reset_pulses = 0;
        start_download(`IDX_PRG);
        send_byte(24'd0, 8'hFE);
        send_byte(24'd1, 8'hBF);
        for (int i = 0; i < 4; i++) send_byte(24'd2 + i, 8'h70 + i);
        end_download();
        expect_write(23'h00BFFE, 8'h70, 1'b0);
        expect_write(23'h00BFFF, 8'h71, 1'b0);
        expect_write(23'h00BFFF, 8'h72, 1'b0);
        expect_write(23'h00BFFF, 8'h73, 1'b0);
        verify_injection(16'hBFFF);
        step(40);
        compare("force_reset_o pulses", reset_pulses, 0);
    endtask

    task automatic tap_download();
        restart_gaps = 0;
        start_download(`IDX_TAP);
        for (int i = 0; i < 16; i++) begin
            random_byte(tap_bytes[i]);
            // Version 1 image, so the latch must move away from its reset value
            if (i == `TAP_VERSION_OFFSET) tap_bytes[i][0] = 1'b1;
            send_byte(i, tap_bytes[i]);
        end
        end_download();
        for (int i = 0; i < 16; i++) expect_write(`TAP_MEM_START + i, tap_bytes[i], 1'b0);
        compare("tap_restart_o low cycles in download", restart_gaps, 0);
        compare("tap_version_o", tap_version, tap_bytes[`TAP_VERSION_OFFSET][0]);
    endtask

    task automatic tape_playback();
        tap_q.delete();
        tap_fifo_full = 1'b1;
        repeat (4) phase_cycle();
        compare("tap_o.wrreq count while full", tap_q.size(), 0);
        tap_fifo_full = 1'b0;
        while (tap_q.size() < 16) phase_cycle();
        repeat (4) phase_cycle();
        compare("tap_o.wrreq count", tap_q.size(), 16);
        for (int i = 0; i < 16 && i < tap_q.size(); i++) begin
            compare("tap_o.data", tap_q[i], tap_bytes[i]);
        end
    endtask

    task automatic cpu_kernal_access();
        p2_h    = 1'b1;
        ntsc    = 1'b0;
        cpu_req = '{addr: 16'hE123, wdata: 8'h00, sel: 1'b1, r_wn: 1'b1};
        @(negedge clk_sys);
        compare("mem_o.addr", mem_bus.addr, 23'h00E123);
        compare("mem_o.oe", mem_bus.oe, 1'b1);
        step(1);
        ntsc = 1'b1;
        @(negedge clk_sys);
        compare("mem_o.addr", mem_bus.addr, 23'h01E123);
        step(1);
        cpu_req.r_wn  = 1'b0;
        cpu_req.wdata = 8'h5A;
        @(negedge clk_sys);
        compare("mem_o.we", mem_bus.we, 1'b1);
        compare("mem_o.oe", mem_bus.oe, 1'b0);
        compare("mem_o.wdata", mem_bus.wdata, 8'h5A);
        step(1);
        cpu_req = '0;
        step(1);
        wr_q.delete();
    endtask

    initial begin
        reset         = 1'b1;
        dl            = '0;
        no_load_addr  = 1'b0;
        ntsc          = 1'b0;
        p2_h          = 1'b1;
        cpu_req       = '0;
        tap_fifo_full = 1'b0;
        repeat (8) @(posedge clk_sys);
        #DRIVE_DELAY;
        reset = 1'b0;
        step(2);

        rom_download();
        report_test("rom download");
        prg_at_1100();
        report_test("prg at $1100");
        cartridge_autostart();
        report_test("cartridge autostart and ceiling");
        tap_download();
        report_test("tap download");
        tape_playback();
        report_test("tape playback");
        cpu_kernal_access();
        report_test("cpu kernal access");

        $display("Summary: %0d tests passed, %0d failed, %0d errors", passed, failed, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
